/* all.f */
hw/cpuPkg.sv
hw/alu.sv
hw/regFile.sv
hw/instDecode.sv
hw/cpuCtrl.sv
hw/cpuDatapath.sv
hw/mipsCpu.sv
tb/tbClock.sv
tb/mipsCpu_chk.sv
tb/mipsCpuTb.sv

/* run.sh */
#!/bin/sh
# build and run the mipsCpu testbench with Verilator
cd "$(dirname "$0")" &&
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module mipsCpuTb -o simv &&
	./obj_dir/simv ||
	exit 1

/* tb/mipsCpuTb.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCpuTb import cpuPkg::*; ;
	localparam int PROG_LEN = 48;
	localparam int MAX_DELAY = 3;
	localparam int TIMEOUT_CYCLES = 40 * MAX_DELAY * PROG_LEN;
	localparam logic [31:0] FINAL_PC = 32'd184; // addiu r30 marker

	logic clk, rst;
	logic [31:0] pc, instruction, address, writeData, readData, rfWdata, retirePc;
	logic instReqValid, instReqReady, instValid, instReady;
	logic memWrite, memRead, memReqReady, readDataValid, readDataReady, rfWen;
	logic [4:0] rfWaddr;

	logic [31:0] imem [64];
	logic [31:0] dmem [256];
	logic [31:0] refMem [256];
	logic [31:0] refRegs [32];
	logic [31:0] refPc;
	logic [31:0] lfsr;

	// memory model state
	logic [31:0] fetchAddr, readAddr;
	logic fetchPending, readPending;
	logic [1:0] reqWait, respWait, memWait, rdWait;

	// comparison state
	logic firstReq;
	logic instWaiting, dataWaiting; // cpu sits in IW or RDW
	logic expWen, expSt;
	logic [4:0] expWa;
	logic [31:0] expWd, expSa, expSd, evPc;
	instWord_u expInst;

	tbClock tbClock_i (.clk(clk), .rst(rst));

	mipsCpu mipsCpu_i (.*);

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
	endfunction

	task automatic drawDelay(output logic [1:0] dly);
		dly[0] = lfsr[0];
		lfsr = lfsrStep(lfsr);
		dly[1] = lfsr[0];
		lfsr = lfsrStep(lfsr);
	endtask

	function automatic logic [31:0] rType(input logic [4:0] rs, input logic [4:0] rt,
		input logic [4:0] rd, input logic [4:0] sh, input logic [5:0] fn);
		return {OP_SPECIAL, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] fillWord(input int idx);
		return (idx * 32'h9e37_79b9) ^ 32'h5a5a_0000; // differs for every index
	endfunction

	// architectural model, one instruction per call
	function automatic void refStep(output logic wen, output logic st, output logic [4:0] wa,
		output logic [31:0] wd, output logic [31:0] sa, output logic [31:0] sd,
		output instWord_u w);
		logic [31:0] rsV, rtV, immS, immZ, nxt, ea;
		logic [5:0] op, fn;
		logic [4:0] sh;
		w = imem[refPc[7:2]];
		op = w[31:26];
		fn = w[5:0];
		sh = w[10:6];
		rsV = refRegs[w[25:21]];
		rtV = refRegs[w[20:16]];
		immS = {{16{w[15]}}, w[15:0]};
		immZ = {16'h0, w[15:0]};
		ea = rsV + immS;
		{wen, st, wa, wd, sa, sd} = '0;
		nxt = refPc + 32'd4;
		wa = w[20:16];
		case (op)
			OP_SPECIAL: if (w != '0) begin
				wen = 1'b1;
				wa = w[15:11];
				case (fn)
					FN_SLL: wd = rtV << sh;
					FN_SRL: wd = rtV >> sh;
					FN_SRA: wd = $signed(rtV) >>> sh;
					FN_SLLV: wd = rtV << rsV[4:0];
					FN_SRLV: wd = rtV >> rsV[4:0];
					FN_SRAV: wd = $signed(rtV) >>> rsV[4:0];
					FN_ADD: wd = rsV + rtV;
					FN_SUB: wd = rsV - rtV;
					FN_AND: wd = rsV & rtV;
					FN_OR: wd = rsV | rtV;
					FN_XOR: wd = rsV ^ rtV;
					FN_SLT: wd = {31'b0, $signed(rsV) < $signed(rtV)};
					FN_SLTU: wd = {31'b0, rsV < rtV};
					FN_JR: begin
						wen = 1'b0;
						nxt = rsV;
					end
					default: wen = 1'b0;
				endcase
			end
			OP_J: nxt = {refPc[31:28], w[25:0], 2'b00};
			OP_JAL: begin
				wen = 1'b1;
				wa = 5'd31;
				wd = refPc + 32'd8;
				nxt = {refPc[31:28], w[25:0], 2'b00};
			end
			OP_BEQ: if (rsV == rtV) nxt = refPc + 32'd4 + (immS << 2);
			OP_BNE: if (rsV != rtV) nxt = refPc + 32'd4 + (immS << 2);
			OP_ADDIU: {wen, wd} = {1'b1, ea};
			OP_SLTI: {wen, wd} = {1'b1, 31'b0, $signed(rsV) < $signed(immS)};
			OP_SLTIU: {wen, wd} = {1'b1, 31'b0, rsV < immS};
			OP_ANDI: {wen, wd} = {1'b1, rsV & immZ};
			OP_ORI: {wen, wd} = {1'b1, rsV | immZ};
			OP_XORI: {wen, wd} = {1'b1, rsV ^ immZ};
			OP_LUI: {wen, wd} = {1'b1, w[15:0], 16'h0};
			OP_LW: {wen, wd} = {1'b1, refMem[ea[9:2]]};
			OP_SW: begin
				st = 1'b1;
				sa = {ea[31:2], 2'b00};
				sd = rtV;
				refMem[ea[9:2]] = rtV;
			end
			default: ;
		endcase
		if (wen && wa != 5'd0)
			refRegs[wa] = wd;
		refPc = nxt;
	endfunction

	task automatic failWith(input string what);
		$display("%s at %0t", what, $time);
		$display("TEST FAILED");
		$fatal(1, "stopped on first error");
	endtask

	task automatic checkWord(input string name, input logic [DATA_WIDTH-1:0] got,
		input logic [DATA_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic checkRegAddr(input string name, input logic [REG_ADDR_WIDTH-1:0] got,
		input logic [REG_ADDR_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "register index check failed");
		end
	endtask

	task automatic checkInst(input string name, input instWord_u got, input instWord_u exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "instruction check failed");
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
			$display("TEST FAILED");
			$fatal(1, "strobe check failed");
		end
	endtask

	// step past silent instructions up to the next retiring one
	task automatic nextEvent();
		int n;
		n = 0;
		do begin
			evPc = refPc;
			refStep(expWen, expSt, expWa, expWd, expSa, expSd, expInst);
			n++;
		end while (!expWen && !expSt && n < 64);
		if (!expWen && !expSt)
			failWith("model ran 64 instructions without a retiring one");
	endtask

	initial begin
		lfsr = 32'ha560_83f4;
		instReqReady = 1'b0;
		instruction = '0;
		instValid = 1'b0;
		memReqReady = 1'b0;
		readData = '0;
		readDataValid = 1'b0;
		firstReq = 1'b0;
		instWaiting = 1'b0;
		dataWaiting = 1'b0;
		refPc = '0;
		for (int i = 0; i < 32; i++)
			refRegs[i] = '0;
		for (int i = 0; i < 256; i++) begin
			dmem[i] = fillWord(i);
			refMem[i] = fillWord(i);
		end
		for (int i = 0; i < 64; i++)
			imem[i] = iType(OP_ADDIU, 5'd0, 5'd28, 16'h0bad); // never reached
		imem[0] = iType(OP_ADDIU, 5'd0, 5'd1, 16'h1234);
		imem[1] = iType(OP_ADDIU, 5'd0, 5'd2, 16'hfffb);
		imem[2] = iType(OP_LUI, 5'd0, 5'd3, 16'h8000);
		imem[3] = rType(5'd1, 5'd2, 5'd4, 5'd0, FN_ADD);
		imem[4] = rType(5'd1, 5'd2, 5'd5, 5'd0, FN_SUB);
		imem[5] = rType(5'd1, 5'd2, 5'd6, 5'd0, FN_AND);
		imem[6] = rType(5'd1, 5'd3, 5'd7, 5'd0, FN_OR);
		imem[7] = rType(5'd2, 5'd3, 5'd8, 5'd0, FN_XOR);
		imem[8] = rType(5'd2, 5'd1, 5'd9, 5'd0, FN_SLT);
		imem[9] = rType(5'd2, 5'd1, 5'd10, 5'd0, FN_SLTU);
		imem[10] = rType(5'd0, 5'd1, 5'd11, 5'd4, FN_SLL);
		imem[11] = rType(5'd0, 5'd3, 5'd12, 5'd3, FN_SRL);
		imem[12] = rType(5'd0, 5'd3, 5'd13, 5'd3, FN_SRA);
		imem[13] = iType(OP_ADDIU, 5'd0, 5'd14, 16'd7);
		imem[14] = rType(5'd14, 5'd1, 5'd15, 5'd0, FN_SLLV);
		imem[15] = rType(5'd14, 5'd2, 5'd16, 5'd0, FN_SRLV);
		imem[16] = rType(5'd14, 5'd2, 5'd17, 5'd0, FN_SRAV);
		imem[17] = iType(OP_ANDI, 5'd2, 5'd18, 16'hff0f);
		imem[18] = iType(OP_ORI, 5'd1, 5'd19, 16'h8001);
		imem[19] = iType(OP_XORI, 5'd2, 5'd20, 16'hffff);
		imem[20] = iType(OP_SLTI, 5'd2, 5'd21, 16'hffff);
		imem[21] = iType(OP_SLTIU, 5'd1, 5'd22, 16'hffff);
		imem[22] = iType(OP_ADDIU, 5'd0, 5'd0, 16'd55); // $0 stays zero
		imem[23] = rType(5'd0, 5'd1, 5'd23, 5'd0, FN_ADD);
		imem[24] = '0; // nop
		imem[25] = iType(OP_ADDIU, 5'd0, 5'd24, 16'h0100);
		imem[26] = iType(OP_SW, 5'd24, 5'd1, 16'd0);
		imem[27] = iType(OP_SW, 5'd24, 5'd2, 16'd4);
		imem[28] = iType(OP_LW, 5'd24, 5'd25, 16'd0);
		imem[29] = iType(OP_LW, 5'd24, 5'd26, 16'd4);
		imem[30] = iType(OP_LW, 5'd24, 5'd27, 16'd8);
		imem[31] = iType(OP_BEQ, 5'd1, 5'd2, 16'd5); // not taken
		imem[32] = iType(OP_BNE, 5'd1, 5'd2, 16'd1);
		imem[34] = iType(OP_BEQ, 5'd25, 5'd1, 16'd1);
		imem[36] = {OP_JAL, 26'd40};
		imem[38] = {OP_J, 26'd44};
		imem[40] = iType(OP_ADDIU, 5'd31, 5'd29, 16'd0);
		imem[41] = rType(5'd31, 5'd0, 5'd0, 5'd0, FN_JR);
		imem[44] = iType(OP_ADDIU, 5'd14, 5'd14, 16'hffff); // countdown loop
		imem[45] = iType(OP_BNE, 5'd14, 5'd0, 16'hfffe);
		imem[46] = iType(OP_ADDIU, 5'd0, 5'd30, 16'h007e);
		imem[47] = {OP_J, 26'd47};
	end

	// instruction and data memories with random waits
	always @(posedge clk) begin
		if (rst) begin
			fetchPending = 1'b0;
			readPending = 1'b0;
			{reqWait, respWait, memWait, rdWait} = '0;
		end else begin
			if (instReqValid && instReqReady) begin
				if (pc > 32'd252)
					failWith("fetch outside the program memory");
				instReqReady <= 1'b0;
				fetchAddr = pc;
				fetchPending = 1'b1;
				drawDelay(respWait);
				drawDelay(reqWait);
			end else if (instReqValid && reqWait == 0)
				instReqReady <= 1'b1;
			else if (instReqValid)
				reqWait = reqWait - 2'd1;

			if (instValid && instReady)
				instValid <= 1'b0;
			else if (fetchPending && respWait == 0) begin
				instValid <= 1'b1;
				instruction <= imem[fetchAddr[7:2]];
				fetchPending = 1'b0;
			end else if (fetchPending)
				respWait = respWait - 2'd1;

			if ((memRead || memWrite) && memReqReady) begin
				memReqReady <= 1'b0;
				if (memWrite)
					dmem[address[9:2]] = writeData;
				if (memRead) begin
					readAddr = address;
					readPending = 1'b1;
					drawDelay(rdWait);
				end
				drawDelay(memWait);
			end else if ((memRead || memWrite) && memWait == 0)
				memReqReady <= 1'b1;
			else if (memRead || memWrite)
				memWait = memWait - 2'd1;

			if (readDataValid && readDataReady)
				readDataValid <= 1'b0;
			else if (readPending && rdWait == 0) begin
				readDataValid <= 1'b1;
				readData <= dmem[readAddr[9:2]];
				readPending = 1'b0;
			end else if (readPending)
				rdWait = rdWait - 2'd1;
		end
	end

	// compares every retire event with the model
	always @(posedge clk) begin
		if (!rst) begin
			if (!firstReq && (memRead || memWrite || rfWen))
				failWith("control output active before the first fetch");
			if (!firstReq && instReqValid) begin
				checkWord("pc", pc, 32'd0);
				firstReq = 1'b1;
			end
			if (firstReq) begin
				// ready only while a response is owed
				checkBit("instReady", instReady, instWaiting);
				checkBit("readDataReady", readDataReady, dataWaiting);
			end
			if (instReqValid && instReqReady)
				instWaiting = 1'b1;
			else if (instWaiting && instValid)
				instWaiting = 1'b0;
			if (memRead && memReqReady)
				dataWaiting = 1'b1;
			else if (dataWaiting && readDataValid)
				dataWaiting = 1'b0;
			if (rfWen || (memWrite && memReqReady)) begin
				nextEvent();
				if (rfWen) begin
					if (!expWen)
						failWith("register write where the model expects a store");
					checkInst("inst", mipsCpu_i.inst, expInst);
					checkRegAddr("rfWaddr", rfWaddr, expWa);
					checkWord("rfWdata", rfWdata, expWd);
					checkWord("retirePc", retirePc, refPc);
				end else begin
					if (!expSt)
						failWith("store where the model expects a register write");
					checkWord("address", address, expSa);
					checkWord("writeData", writeData, expSd);
				end
				if (evPc == FINAL_PC) begin
					$display("TEST PASSED");
					$finish;
				end
			end
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge clk);
		$display("watchdog expired after %0d cycles", TIMEOUT_CYCLES);
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end
endmodule

`default_nettype wire

/* tb/mipsCpu_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCpu_chk import cpuPkg::*; (
	input logic clk,
	input logic rst,
	input logic [STATE_WIDTH-1:0] state,
	input logic [DATA_WIDTH-1:0] pc,
	input logic instReqValid,
	input logic instReqReady,
	input logic memRead,
	input logic memWrite,
	input logic memReqReady,
	input logic [DATA_WIDTH-1:0] address,
	input logic [DATA_WIDTH-1:0] writeData
);
	stateOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(state))
		else $error("controller state is not one-hot");

	noReadWrite: assert property (@(posedge clk) disable iff (rst) !(memRead && memWrite))
		else $error("memRead and memWrite high together");

	// a waiting request keeps its payload
	reqStable: assert property (@(posedge clk) disable iff (rst)
		(memRead || memWrite) && !memReqReady |=>
		$stable(memRead) && $stable(memWrite) && $stable(address) && $stable(writeData))
		else $error("data request changed while waiting for memReqReady");

	fetchStable: assert property (@(posedge clk) disable iff (rst)
		instReqValid && !instReqReady |=> instReqValid && $stable(pc))
		else $error("fetch request changed while waiting for instReqReady");

	quietAfterReset: assert property (@(posedge clk) $fell(rst) |-> !instReqValid)
		else $error("instReqValid high right after reset");
endmodule

bind mipsCpu mipsCpu_chk mipsCpu_chk_i (
	.clk(clk),
	.rst(rst),
	.state(cpuCtrl_i.state),
	.pc(pc),
	.instReqValid(instReqValid),
	.instReqReady(instReqReady),
	.memRead(memRead),
	.memWrite(memWrite),
	.memReqReady(memReqReady),
	.address(address),
	.writeData(writeData)
);

`default_nettype wire

/* tb/tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock (
	output logic clk,
	output logic rst
);
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
	end
endmodule

`default_nettype wire

/* hw/mipsCpu.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsCpu import cpuPkg::*; (
	input logic clk,
	input logic rst,
	output logic [DATA_WIDTH-1:0] pc,
	output logic instReqValid,
	input logic instReqReady,
	input logic [DATA_WIDTH-1:0] instruction,
	input logic instValid,
	output logic instReady,
	output logic [DATA_WIDTH-1:0] address,
	output logic memWrite,
	output logic memRead,
	output logic [DATA_WIDTH-1:0] writeData,
	input logic memReqReady,
	input logic [DATA_WIDTH-1:0] readData,
	input logic readDataValid,
	output logic readDataReady,
	output logic rfWen,
	output logic [REG_ADDR_WIDTH-1:0] rfWaddr,
	output logic [DATA_WIDTH-1:0] rfWdata,
	output logic [DATA_WIDTH-1:0] retirePc
);
	logic irWrite, pcWrite, pcWriteCond, aluSrcA, useAddAlu, holdExec, mdrWrite, regWrite;
	logic [1:0] aluSrcB;

	instWord_u inst;
	logic [ALU_OP_WIDTH-1:0] aluOp;
	logic isShift, shiftByReg, immZeroExt, isBranch, branchOnEqual, isJump, jumpReg;
	logic isLink, isLoad, isStore, isLui, destIsRd, writesReg, isNop;
	logic [REG_ADDR_WIDTH-1:0] rs, rt, rd;
	logic [4:0] shamt;
	logic [15:0] imm16;
	logic [25:0] jumpIndex;

	logic [DATA_WIDTH-1:0] aluA, aluB, aluResult, rfRdata1, rfRdata2;
	logic [ALU_OP_WIDTH-1:0] aluOpSel;
	logic aluShift, aluZero;

	cpuCtrl cpuCtrl_i (.*);

	instDecode instDecode_i (.*);

	cpuDatapath cpuDatapath_i (.*);

	alu alu_i (
		.a(aluA),
		.b(aluB),
		.aluOp(aluOpSel),
		.isShift(aluShift),
		.shiftByReg(shiftByReg),
		.shamt(shamt),
		.result(aluResult),
		.zero(aluZero)
	);

	regFile regFile_i (
		.clk(clk),
		.raddr1(rs),
		.raddr2(rt),
		.wen(rfWen),
		.waddr(rfWaddr),
		.wdata(rfWdata),
		.rdata1(rfRdata1),
		.rdata2(rfRdata2)
	);

	assign retirePc = pc; // pc register seen at retire
endmodule

`default_nettype wire

/* hw/cpuDatapath.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuDatapath import cpuPkg::*; (
	input logic clk,
	input logic rst,
	input logic [DATA_WIDTH-1:0] instruction,
	input logic [DATA_WIDTH-1:0] readData,
	input logic irWrite,
	input logic pcWrite,
	input logic pcWriteCond,
	input logic aluSrcA,
	input logic [1:0] aluSrcB,
	input logic useAddAlu,
	input logic holdExec,
	input logic mdrWrite,
	input logic regWrite,
	input logic [ALU_OP_WIDTH-1:0] aluOp,
	input logic isShift,
	input logic immZeroExt,
	input logic branchOnEqual,
	input logic isJump,
	input logic jumpReg,
	input logic isLoad,
	input logic isLui,
	input logic destIsRd,
	input logic writesReg,
	input logic [REG_ADDR_WIDTH-1:0] rt,
	input logic [REG_ADDR_WIDTH-1:0] rd,
	input logic [15:0] imm16,
	input logic [25:0] jumpIndex,
	input logic [DATA_WIDTH-1:0] aluResult,
	input logic aluZero,
	input logic [DATA_WIDTH-1:0] rfRdata1,
	input logic [DATA_WIDTH-1:0] rfRdata2,
	output instWord_u inst,
	output logic [DATA_WIDTH-1:0] aluA,
	output logic [DATA_WIDTH-1:0] aluB,
	output logic [ALU_OP_WIDTH-1:0] aluOpSel,
	output logic aluShift,
	output logic [DATA_WIDTH-1:0] pc,
	output logic [DATA_WIDTH-1:0] address,
	output logic [DATA_WIDTH-1:0] writeData,
	output logic rfWen,
	output logic [REG_ADDR_WIDTH-1:0] rfWaddr,
	output logic [DATA_WIDTH-1:0] rfWdata
);
	logic [DATA_WIDTH-1:0] aluOut; // execute result, also the held branch target
	logic [DATA_WIDTH-1:0] mdr;
	logic [DATA_WIDTH-1:0] immExt;
	logic [DATA_WIDTH-1:0] branchOff;
	logic [DATA_WIDTH-1:0] pcNext;
	logic branchTaken;

	assign immExt = immZeroExt ? {16'h0, imm16} : {{16{imm16[15]}}, imm16};
	assign branchOff = {{14{imm16[15]}}, imm16, 2'b00};

	assign aluA = aluSrcA ? rfRdata1 : pc;
	always_comb begin
		case (aluSrcB)
			2'b00: aluB = rfRdata2;
			2'b01: aluB = 32'd4;
			2'b10: aluB = destIsRd ? rfRdata2 : immExt; // R-type vs immediate
			default: aluB = branchOff;
		endcase
	end

	// address arithmetic must not pick up a stale shift
	assign aluOpSel = useAddAlu ? ALU_ADD : aluOp;
	assign aluShift = isShift && !useAddAlu;

	assign branchTaken = pcWriteCond && (aluZero == branchOnEqual);
	assign pcNext = irWrite ? aluResult :
		!isJump ? aluOut :
		jumpReg ? rfRdata1 : {pc[31:28], jumpIndex, 2'b00};

	always_ff @(posedge clk) begin
		if (rst)
			pc <= '0;
		else if (pcWrite || branchTaken)
			pc <= pcNext;
	end

	always_ff @(posedge clk) begin
		if (irWrite)
			inst <= instruction;
		if (!holdExec)
			aluOut <= aluResult;
		if (mdrWrite)
			mdr <= readData;
	end

	assign address = {aluOut[DATA_WIDTH-1:2], 2'b00}; // word aligned
	assign writeData = rfRdata2;

	assign rfWen = regWrite && writesReg;
	assign rfWaddr = destIsRd ? rd : rt;
	assign rfWdata = isLoad ? mdr : isLui ? {imm16, 16'h0} : aluOut;
endmodule

`default_nettype wire

/* hw/cpuCtrl.sv */
`timescale 1ns/1ps
`default_nettype none

module cpuCtrl import cpuPkg::*; (
	input logic clk,
	input logic rst,
	input logic instReqReady,
	input logic instValid,
	input logic memReqReady,
	input logic readDataValid,
	input logic isNop,
	input logic isBranch,
	input logic isJump,
	input logic isLink,
	input logic isLoad,
	input logic isStore,
	output logic instReqValid,
	output logic instReady,
	output logic memRead,
	output logic memWrite,
	output logic readDataReady,
	output logic irWrite,
	output logic pcWrite,
	output logic pcWriteCond,
	output logic aluSrcA,
	output logic [1:0] aluSrcB,
	output logic useAddAlu,
	output logic holdExec,
	output logic mdrWrite,
	output logic regWrite
);
	logic [STATE_WIDTH-1:0] state;
	logic [STATE_WIDTH-1:0] stateNext;
	logic inInit, inIf, inIw, inId, inEx, inLd, inSt, inRdw, inWb;

	assign inInit = |(state & ST_INIT);
	assign inIf = |(state & ST_IF);
	assign inIw = |(state & ST_IW);
	assign inId = |(state & ST_ID);
	assign inEx = |(state & ST_EX);
	assign inLd = |(state & ST_LD);
	assign inSt = |(state & ST_ST);
	assign inRdw = |(state & ST_RDW);
	assign inWb = |(state & ST_WB);

	always_ff @(posedge clk) begin
		if (rst)
			state <= ST_INIT;
		else
			state <= stateNext;
	end

	always_comb begin
		stateNext = ST_IF;
		case (1'b1)
			inInit: stateNext = ST_IF;
			inIf: stateNext = instReqReady ? ST_IW : ST_IF;
			inIw: stateNext = instValid ? ST_ID : ST_IW;
			inId: stateNext = isNop ? ST_IF : ST_EX;
			inEx: begin
				if (isBranch || (isJump && !isLink))
					stateNext = ST_IF; // jal still needs its write-back
				else if (isStore)
					stateNext = ST_ST;
				else if (isLoad)
					stateNext = ST_LD;
				else
					stateNext = ST_WB;
			end
			inLd: stateNext = memReqReady ? ST_RDW : ST_LD;
			inSt: stateNext = memReqReady ? ST_IF : ST_ST;
			inRdw: stateNext = readDataValid ? ST_WB : ST_RDW;
			inWb: stateNext = ST_IF;
			default: stateNext = ST_IF;
		endcase
	end

	// channel handshakes
	assign instReqValid = inIf;
	assign instReady = inInit || inIw;
	assign memRead = inLd;
	assign memWrite = inSt;
	assign readDataReady = inInit || inRdw;

	assign irWrite = inIw && instValid;
	assign pcWrite = (inIw && instValid) || (inEx && isJump);
	assign pcWriteCond = inEx && isBranch;

	// IW: pc+4, ID: branch target, EX with jal: link value
	assign useAddAlu = inIw || inId || (inEx && isLink);
	assign aluSrcA = inEx && !isLink;
	assign aluSrcB = (inIw || (inEx && isLink)) ? 2'b01 :
		inId ? 2'b11 :
		(inEx && !isBranch) ? 2'b10 : 2'b00;

	assign holdExec = inLd || inSt || inRdw; // keeps address and writeData still
	assign mdrWrite = inRdw && readDataValid;
	assign regWrite = inWb;
endmodule

`default_nettype wire

/* hw/instDecode.sv */
`timescale 1ns/1ps
`default_nettype none

module instDecode import cpuPkg::*; (
	input instWord_u inst,
	output logic [ALU_OP_WIDTH-1:0] aluOp,
	output logic isShift,
	output logic shiftByReg,
	output logic immZeroExt,
	output logic isBranch,
	output logic branchOnEqual,
	output logic isJump,
	output logic jumpReg,
	output logic isLink,
	output logic isLoad,
	output logic isStore,
	output logic isLui,
	output logic destIsRd,
	output logic writesReg,
	output logic isNop,
	output logic [REG_ADDR_WIDTH-1:0] rs,
	output logic [REG_ADDR_WIDTH-1:0] rt,
	output logic [REG_ADDR_WIDTH-1:0] rd,
	output logic [4:0] shamt,
	output logic [15:0] imm16,
	output logic [25:0] jumpIndex
);
	logic [OPCODE_WIDTH-1:0] opcode;
	logic [FUNCT_WIDTH-1:0] funct;

	assign opcode = inst.i.opcode;
	assign funct = inst.r.funct;

	assign rs = inst.r.rs;
	assign rt = inst.i.rt;
	assign rd = isLink ? REG_RA : inst.r.rd;
	assign shamt = inst.r.shamt;
	assign imm16 = inst.i.imm16;
	assign jumpIndex = {inst.i.rs, inst.i.rt, inst.i.imm16};
	assign isNop = (inst == '0);

	always_comb begin
		aluOp = ALU_ADD;
		isShift = 1'b0;
		shiftByReg = 1'b0;
		immZeroExt = 1'b0;
		isBranch = 1'b0;
		branchOnEqual = 1'b0;
		isJump = 1'b0;
		jumpReg = 1'b0;
		isLink = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		isLui = 1'b0;
		destIsRd = 1'b0;
		writesReg = 1'b0;
		case (opcode)
			OP_SPECIAL: begin
				destIsRd = 1'b1;
				writesReg = 1'b1;
				case (funct)
					FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV: begin
						isShift = 1'b1;
						shiftByReg = funct[2];
						aluOp = {1'b0, funct[1:0]}; // shift type for the alu
					end
					FN_JR: begin
						isJump = 1'b1;
						jumpReg = 1'b1;
						writesReg = 1'b0;
					end
					FN_ADD: aluOp = ALU_ADD;
					FN_SUB: aluOp = ALU_SUB;
					FN_AND: aluOp = ALU_AND;
					FN_OR: aluOp = ALU_OR;
					FN_XOR: aluOp = ALU_XOR;
					FN_SLT: aluOp = ALU_SLT;
					FN_SLTU: aluOp = ALU_SLTU;
					default: writesReg = 1'b0;
				endcase
			end
			OP_J: isJump = 1'b1;
			OP_JAL: begin
				isJump = 1'b1;
				isLink = 1'b1;
				destIsRd = 1'b1; // rd forced to 31
				writesReg = 1'b1;
			end
			OP_BEQ, OP_BNE: begin
				isBranch = 1'b1;
				branchOnEqual = (opcode == OP_BEQ);
				aluOp = ALU_SUB;
			end
			OP_ADDIU: writesReg = 1'b1;
			OP_SLTI: begin
				aluOp = ALU_SLT;
				writesReg = 1'b1;
			end
			OP_SLTIU: begin
				aluOp = ALU_SLTU;
				writesReg = 1'b1;
			end
			OP_ANDI, OP_ORI, OP_XORI: begin
				aluOp = (opcode == OP_ANDI) ? ALU_AND : (opcode == OP_ORI) ? ALU_OR : ALU_XOR;
				immZeroExt = 1'b1;
				writesReg = 1'b1;
			end
			OP_LUI: begin
				isLui = 1'b1;
				writesReg = 1'b1;
			end
			OP_LW: begin
				isLoad = 1'b1;
				writesReg = 1'b1;
			end
			OP_SW: isStore = 1'b1;
			default: writesReg = 1'b0;
		endcase
	end
endmodule

`default_nettype wire

/* hw/regFile.sv */
`timescale 1ns/1ps
`default_nettype none

module regFile import cpuPkg::*; (
	input logic clk,
	input logic [REG_ADDR_WIDTH-1:0] raddr1,
	input logic [REG_ADDR_WIDTH-1:0] raddr2,
	input logic wen,
	input logic [REG_ADDR_WIDTH-1:0] waddr,
	input logic [DATA_WIDTH-1:0] wdata,
	output logic [DATA_WIDTH-1:0] rdata1,
	output logic [DATA_WIDTH-1:0] rdata2
);
	logic [DATA_WIDTH-1:0] regs [2**REG_ADDR_WIDTH];

	always_ff @(posedge clk) begin
		if (wen)
			regs[waddr] <= wdata;
	end

	// $0 reads zero whatever was written
	assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];
endmodule

`default_nettype wire

/* hw/alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu import cpuPkg::*; (
	input logic [DATA_WIDTH-1:0] a,
	input logic [DATA_WIDTH-1:0] b,
	input logic [ALU_OP_WIDTH-1:0] aluOp,
	input logic isShift,
	input logic shiftByReg,
	input logic [4:0] shamt,
	output logic [DATA_WIDTH-1:0] result,
	output logic zero
);
	logic [4:0] shiftAmt;

	assign shiftAmt = shiftByReg ? a[4:0] : shamt; // variable forms use rs

	always_comb begin
		if (isShift) begin
			// low two bits carry the funct shift type
			case (aluOp[1:0])
				2'b10: result = b >> shiftAmt;
				2'b11: result = $signed(b) >>> shiftAmt;
				default: result = b << shiftAmt;
			endcase
		end else begin
			case (aluOp)
				ALU_AND: result = a & b;
				ALU_OR: result = a | b;
				ALU_XOR: result = a ^ b;
				ALU_ADD: result = a + b;
				ALU_SUB: result = a - b;
				ALU_SLT: result = {{(DATA_WIDTH-1){1'b0}}, $signed(a) < $signed(b)};
				ALU_SLTU: result = {{(DATA_WIDTH-1){1'b0}}, a < b};
				default: result = a + b;
			endcase
		end
	end

	assign zero = (result == '0); // beq/bne compare via sub
endmodule

`default_nettype wire

/* hw/cpuPkg.sv */
`default_nettype none

package cpuPkg;
	localparam int DATA_WIDTH = 32;
	localparam int REG_ADDR_WIDTH = 5;
	localparam int OPCODE_WIDTH = 6;
	localparam int FUNCT_WIDTH = 6;
	localparam int ALU_OP_WIDTH = 3;
	localparam int STATE_WIDTH = 9;

	// alu codes
	localparam logic [ALU_OP_WIDTH-1:0] ALU_AND = 3'b000;
	localparam logic [ALU_OP_WIDTH-1:0] ALU_OR = 3'b001;
	localparam logic [ALU_OP_WIDTH-1:0] ALU_ADD = 3'b010;
	localparam logic [ALU_OP_WIDTH-1:0] ALU_SLTU = 3'b011;
	localparam logic [ALU_OP_WIDTH-1:0] ALU_XOR = 3'b100;
	localparam logic [ALU_OP_WIDTH-1:0] ALU_SUB = 3'b110;
	localparam logic [ALU_OP_WIDTH-1:0] ALU_SLT = 3'b111;

	localparam logic [OPCODE_WIDTH-1:0] OP_SPECIAL = 6'b000000;
	localparam logic [OPCODE_WIDTH-1:0] OP_J = 6'b000010;
	localparam logic [OPCODE_WIDTH-1:0] OP_JAL = 6'b000011;
	localparam logic [OPCODE_WIDTH-1:0] OP_BEQ = 6'b000100;
	localparam logic [OPCODE_WIDTH-1:0] OP_BNE = 6'b000101;
	localparam logic [OPCODE_WIDTH-1:0] OP_ADDIU = 6'b001001;
	localparam logic [OPCODE_WIDTH-1:0] OP_SLTI = 6'b001010;
	localparam logic [OPCODE_WIDTH-1:0] OP_SLTIU = 6'b001011;
	localparam logic [OPCODE_WIDTH-1:0] OP_ANDI = 6'b001100;
	localparam logic [OPCODE_WIDTH-1:0] OP_ORI = 6'b001101;
	localparam logic [OPCODE_WIDTH-1:0] OP_XORI = 6'b001110;
	localparam logic [OPCODE_WIDTH-1:0] OP_LUI = 6'b001111;
	localparam logic [OPCODE_WIDTH-1:0] OP_LW = 6'b100011;
	localparam logic [OPCODE_WIDTH-1:0] OP_SW = 6'b101011;

	localparam logic [FUNCT_WIDTH-1:0] FN_SLL = 6'b000000;
	localparam logic [FUNCT_WIDTH-1:0] FN_SRL = 6'b000010;
	localparam logic [FUNCT_WIDTH-1:0] FN_SRA = 6'b000011;
	localparam logic [FUNCT_WIDTH-1:0] FN_SLLV = 6'b000100;
	localparam logic [FUNCT_WIDTH-1:0] FN_SRLV = 6'b000110;
	localparam logic [FUNCT_WIDTH-1:0] FN_SRAV = 6'b000111;
	localparam logic [FUNCT_WIDTH-1:0] FN_JR = 6'b001000;
	localparam logic [FUNCT_WIDTH-1:0] FN_ADD = 6'b100000;
	localparam logic [FUNCT_WIDTH-1:0] FN_SUB = 6'b100010;
	localparam logic [FUNCT_WIDTH-1:0] FN_AND = 6'b100100;
	localparam logic [FUNCT_WIDTH-1:0] FN_OR = 6'b100101;
	localparam logic [FUNCT_WIDTH-1:0] FN_XOR = 6'b100110;
	localparam logic [FUNCT_WIDTH-1:0] FN_SLT = 6'b101010;
	localparam logic [FUNCT_WIDTH-1:0] FN_SLTU = 6'b101011;

	// one-hot controller states
	localparam logic [STATE_WIDTH-1:0] ST_INIT = 9'b000000001;
	localparam logic [STATE_WIDTH-1:0] ST_IF = 9'b000000010;
	localparam logic [STATE_WIDTH-1:0] ST_IW = 9'b000000100;
	localparam logic [STATE_WIDTH-1:0] ST_ID = 9'b000001000;
	localparam logic [STATE_WIDTH-1:0] ST_EX = 9'b000010000;
	localparam logic [STATE_WIDTH-1:0] ST_LD = 9'b000100000;
	localparam logic [STATE_WIDTH-1:0] ST_ST = 9'b001000000;
	localparam logic [STATE_WIDTH-1:0] ST_RDW = 9'b010000000;
	localparam logic [STATE_WIDTH-1:0] ST_WB = 9'b100000000;

	localparam logic [REG_ADDR_WIDTH-1:0] REG_RA = 5'd31; // jal link register

	typedef struct packed {
		logic [OPCODE_WIDTH-1:0] opcode;
		logic [REG_ADDR_WIDTH-1:0] rs;
		logic [REG_ADDR_WIDTH-1:0] rt;
		logic [REG_ADDR_WIDTH-1:0] rd;
		logic [4:0] shamt;
		logic [FUNCT_WIDTH-1:0] funct;
	} instRType_t;

	typedef struct packed {
		logic [OPCODE_WIDTH-1:0] opcode;
		logic [REG_ADDR_WIDTH-1:0] rs;
		logic [REG_ADDR_WIDTH-1:0] rt;
		logic [15:0] imm16;
	} instIType_t;

	// same word, R view and I view
	typedef union packed {
		instRType_t r;
		instIType_t i;
	} instWord_u;
endpackage

`default_nettype wire
